/* build.f */
+incdir+include
design/jtag_pkg.sv
design/jtag_pins_if.sv
design/jtag_host_ctrl.sv
design/jtag_tms_sequencer.sv
design/jtag_scan_shifter.sv
design/jtag_tap_target.sv
design/jtag_subsys_top.sv
verification/jtag_checker.sv
verification/jtag_tb.sv

/* Bender.yml */
package:
  name: jtag_subsys

export_include_dirs:
  - include

sources:
  - files:
      - design/jtag_pkg.sv
      - design/jtag_pins_if.sv
      - design/jtag_host_ctrl.sv
      - design/jtag_tms_sequencer.sv
      - design/jtag_scan_shifter.sv
      - design/jtag_tap_target.sv
      - design/jtag_subsys_top.sv
  - target: simulation
    files:
      - verification/jtag_checker.sv
      - verification/jtag_tb.sv

/* verification/jtag_tb.sv */
// Requests run one at a time; the model assumes the target leaves reset with SCRATCH cleared
`default_nettype none

`include "jtag_config.svh"

module jtag_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import jtag_pkg::*;

    localparam int IRW = `JTAG_TAP_IR_WIDTH;
    localparam int RESP_W = $bits(ir_word_t) + $bits(dr_word_t);
    localparam int TIMEOUT_CYCLES = 40 * 300 * (`JTAG_TCK_DIVISOR + 1);

    logic clk;
    logic reset;
    logic req;
    ir_len_t ir_len;
    ir_word_t ir_in;
    dr_len_t dr_len;
    dr_word_t dr_in;
    logic ack;
    ir_word_t ir_out;
    dr_word_t dr_out;
    int error_count;
    int cycle_cnt = 0;
    logic [IRW - 1:0] model_ir;
    dr_word_t model_scratch;

    jtag_subsys_top dut0 (
        .clk(clk), .reset(reset), .req(req),
        .ir_len(ir_len), .ir_in(ir_in), .dr_len(dr_len), .dr_in(dr_in),
        .ack(ack), .ir_out(ir_out), .dr_out(dr_out)
    );

    jtag_checker chk0 (
        .clk(clk), .req(req), .ack(ack),
        .ir_out(ir_out), .dr_out(dr_out), .error_count(error_count)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    // Reference model of the target registers that runs once per request in issue order
    function automatic logic [RESP_W - 1:0] predict_scan(input int ir_n, input ir_word_t ir_bits,
                                                         input int dr_n, input dr_word_t dr_bits);
        logic [IRW - 1:0] ir_chain;
        dr_word_t dr_chain;
        ir_word_t ir_resp;
        dr_word_t dr_resp;
        int chain_len;
        int i;
        ir_resp = '0;
        dr_resp = '0;
        // Test-Logic-Reset falls back to IDCODE and SCRATCH keeps its value
        if (ir_n == 0 && dr_n == 0)
            model_ir = `JTAG_INST_IDCODE;
        if (ir_n != 0)
        begin
            ir_chain = `JTAG_IR_CAPTURE;
            for (i = 0; i < ir_n; i++)
            begin
                ir_resp[i] = ir_chain[0];
                ir_chain = {ir_bits[i], ir_chain[IRW - 1:1]};
            end
            model_ir = ir_chain;
        end
        if (dr_n != 0)
        begin
            if (model_ir == `JTAG_INST_IDCODE)
            begin
                chain_len = 32;
                dr_chain = dr_word_t'(`JTAG_IDCODE);
            end
            else if (model_ir == `JTAG_INST_SCRATCH)
            begin
                chain_len = 64;
                dr_chain = model_scratch;
            end
            else
            begin
                chain_len = 1;
                dr_chain = '0;
            end
            for (i = 0; i < dr_n; i++)
            begin
                dr_resp[i] = dr_chain[0];
                dr_chain = dr_chain >> 1;
                dr_chain[chain_len - 1] = dr_bits[i];
            end
            if (model_ir == `JTAG_INST_SCRATCH)
                model_scratch = dr_chain;
        end
        return {ir_resp, dr_resp};
    endfunction

    function automatic dr_word_t random_dr_word();
        return {$urandom, $urandom};
    endfunction

    // One four-phase request that holds req for extra cycles after ack
    task automatic run_scan(input int ir_n, input ir_word_t ir_bits,
                            input int dr_n, input dr_word_t dr_bits, input int hold);
        logic [RESP_W - 1:0] expected;
        int k;
        expected = predict_scan(ir_n, ir_bits, dr_n, dr_bits);
        chk0.expect_response(expected[RESP_W - 1:$bits(dr_word_t)],
                             expected[$bits(dr_word_t) - 1:0]);
        @(posedge clk);
        #2;
        ir_len = ir_len_t'(ir_n);
        ir_in = ir_bits;
        dr_len = dr_len_t'(dr_n);
        dr_in = dr_bits;
        req = 1'b1;
        @(posedge clk);
        #2;
        while (!ack)
        begin
            @(posedge clk);
            #2;
        end
        for (k = 0; k < hold; k++)
        begin
            @(posedge clk);
            #2;
        end
        req = 1'b0;
        while (ack)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    initial
    begin
        int unsigned seed;
        int n;
        int ir_n;
        int dr_n;
        seed = 32'hde68_e4ab;
        void'($urandom(seed));
        reset = 1'b1;
        req = 1'b0;
        ir_len = '0;
        ir_in = '0;
        dr_len = '0;
        dr_in = '0;
        model_ir = `JTAG_INST_IDCODE;
        model_scratch = '0;
        repeat (16)
            @(posedge clk);
        #2;
        reset = 1'b0;

        run_scan(0, '0, 32, random_dr_word(), 0);
        run_scan(0, '0, 8, random_dr_word(), 1);
        run_scan(0, '0, 13, random_dr_word(), 0);
        run_scan(4, ir_word_t'(`JTAG_INST_IDCODE), 0, '0, 2);
        run_scan(4, ir_word_t'(`JTAG_INST_SCRATCH), 0, '0, $urandom % 6);
        run_scan(0, '0, 64, random_dr_word(), $urandom % 6);
        run_scan(0, '0, 64, random_dr_word(), $urandom % 6);
        run_scan(0, '0, 20, random_dr_word(), $urandom % 6);
        run_scan(0, '0, 64, random_dr_word(), $urandom % 6);
        // Code 4'hb is unassigned and lands on BYPASS
        run_scan(4, ir_word_t'(4'hb), 16, random_dr_word(), $urandom % 6);
        run_scan(0, '0, 64, random_dr_word(), $urandom % 6);
        run_scan(0, '0, 0, '0, $urandom % 6);
        run_scan(0, '0, 32, random_dr_word(), $urandom % 6);
        run_scan(4, ir_word_t'(`JTAG_INST_SCRATCH), 64, random_dr_word(), $urandom % 6);
        run_scan(9, ir_word_t'($urandom), 40, random_dr_word(), $urandom % 6);

        for (n = 0; n < 20; n++)
        begin
            ir_n = ($urandom % 3 == 0) ? 0 : (($urandom % 2 == 0) ? 4 : 1 + $urandom % 32);
            dr_n = $urandom % 65;
            run_scan(ir_n, ir_word_t'($urandom), dr_n, random_dr_word(), $urandom % 6);
        end

        repeat (4)
            @(posedge clk);
        $display("Checks done: %0d errors, %0d responses missing",
                 error_count, chk0.outstanding());
        if (error_count == 0 && chk0.outstanding() == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles: ack never arrived for the pending request",
                     cycle_cnt);
            $display("Checks done: %0d errors before the timeout", error_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/jtag_checker.sv */
// Expects one queued response per request and treats every rising ack as one response
`default_nettype none

module jtag_checker
(
    input  wire logic               clk,
    input  wire logic               req,
    input  wire logic               ack,
    input  wire jtag_pkg::ir_word_t ir_out,
    input  wire jtag_pkg::dr_word_t dr_out,
    output int                      error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import jtag_pkg::*;

    ir_word_t exp_ir_q[$];
    dr_word_t exp_dr_q[$];
    ir_word_t exp_ir;
    dr_word_t exp_dr;
    ir_word_t held_ir;
    dr_word_t held_dr;
    logic ack_seen = 1'b0;
    logic req_seen = 1'b0;
    int errors = 0;

    assign error_count = errors;

    task automatic expect_response(input ir_word_t ir_exp, input dr_word_t dr_exp);
        exp_ir_q.push_back(ir_exp);
        exp_dr_q.push_back(dr_exp);
    endtask

    function automatic int outstanding();
        return exp_ir_q.size();
    endfunction

    // The DUT updates on the rising edge, so everything is read on the falling one
    always @(negedge clk)
    begin
        if (ack && !ack_seen)
        begin
            if (exp_ir_q.size() == 0)
            begin
                errors++;
                $display("Error: ack rose at %0t with no request outstanding", $time);
            end
            else
            begin
                exp_ir = exp_ir_q.pop_front();
                exp_dr = exp_dr_q.pop_front();
                if (ir_out !== exp_ir)
                begin
                    errors++;
                    $display("FAILED ir_out: got %h expected %h", ir_out, exp_ir);
                end
                if (dr_out !== exp_dr)
                begin
                    errors++;
                    $display("FAILED dr_out: got %h expected %h", dr_out, exp_dr);
                end
            end
            held_ir = ir_out;
            held_dr = dr_out;
        end
        else if (ack && ack_seen)
        begin
            // Response must not move while the requester holds req
            if (ir_out !== held_ir)
            begin
                errors++;
                $display("FAILED ir_out: changed to %h while held at %h", ir_out, held_ir);
            end
            if (dr_out !== held_dr)
            begin
                errors++;
                $display("FAILED dr_out: changed to %h while held at %h", dr_out, held_dr);
            end
        end
        else if (!ack && ack_seen && req_seen)
        begin
            errors++;
            $display("Error: ack fell at %0t while req was still high", $time);
        end
        ack_seen = ack;
        req_seen = req;
    end

endmodule

`default_nettype wire

/* design/jtag_subsys_top.sv */
// Scan host and on-chip TAP target; one request at a time over a four-phase req/ack
`default_nettype none

module jtag_subsys_top
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               req,
    input  wire jtag_pkg::ir_len_t  ir_len,
    input  wire jtag_pkg::ir_word_t ir_in,
    input  wire jtag_pkg::dr_len_t  dr_len,
    input  wire jtag_pkg::dr_word_t dr_in,
    output logic                    ack,
    output jtag_pkg::ir_word_t      ir_out,
    output jtag_pkg::dr_word_t      dr_out
);

    import jtag_pkg::*;

    logic start;
    logic scan_reset;
    logic done;
    logic tck_rise;
    logic tck_fall;
    tap_state_t state;
    ir_len_t scan_ir_len;
    dr_len_t scan_dr_len;
    ir_word_t scan_ir;
    dr_word_t scan_dr;
    ir_word_t ir_captured;
    dr_word_t dr_captured;

    jtag_pins_if pins ();

    jtag_host_ctrl ctrl0 (
        .clk(clk), .reset(reset), .req(req), .ack(ack),
        .ir_len(ir_len), .ir_in(ir_in), .dr_len(dr_len), .dr_in(dr_in),
        .start(start), .scan_reset(scan_reset),
        .scan_ir_len(scan_ir_len), .scan_ir(scan_ir),
        .scan_dr_len(scan_dr_len), .scan_dr(scan_dr),
        .done(done), .ir_captured(ir_captured), .dr_captured(dr_captured),
        .ir_out(ir_out), .dr_out(dr_out)
    );

    jtag_tms_sequencer seq0 (
        .clk(clk), .reset(reset), .start(start), .scan_reset(scan_reset),
        .ir_len(scan_ir_len), .dr_len(scan_dr_len), .pins(pins.host),
        .state(state), .tck_rise(tck_rise), .tck_fall(tck_fall), .done(done)
    );

    // Shifter drives the data pin beside the sequencer on the same strobes
    jtag_scan_shifter shift0 (
        .clk(clk), .reset(reset), .start(start),
        .ir_len(scan_ir_len), .ir_in(scan_ir), .dr_len(scan_dr_len), .dr_in(scan_dr),
        .state(state), .tck_rise(tck_rise), .tck_fall(tck_fall),
        .tdi(pins.tdi), .tdo(pins.tdo),
        .ir_captured(ir_captured), .dr_captured(dr_captured)
    );

    jtag_tap_target tap0 (
        .reset(reset),
        .pins(pins.target)
    );

endmodule

`default_nettype wire

/* design/jtag_tap_target.sv */
// Runs on the TCK pin; trst_n resets the TAP and IR but leaves SCRATCH alone
`default_nettype none

`include "jtag_config.svh"

module jtag_tap_target
(
    input wire logic    reset,
    jtag_pins_if.target pins
);

    import jtag_pkg::*;

    localparam int IRW = `JTAG_TAP_IR_WIDTH;

    tap_state_t state;
    tap_state_t state_nxt;
    logic [IRW - 1:0] ir;
    logic [IRW - 1:0] ir_sh;
    dr_word_t dr_sh;
    dr_word_t scratch;
    logic tap_rst;

    assign tap_rst = reset | ~pins.trst_n;

    always_comb
    begin
        case (state)
            tap_reset:      state_nxt = pins.tms ? tap_reset : tap_idle;
            tap_idle:       state_nxt = pins.tms ? tap_select_dr : tap_idle;
            tap_select_dr:  state_nxt = pins.tms ? tap_select_ir : tap_capture_dr;
            tap_capture_dr: state_nxt = pins.tms ? tap_exit1_dr : tap_shift_dr;
            tap_shift_dr:   state_nxt = pins.tms ? tap_exit1_dr : tap_shift_dr;
            tap_exit1_dr:   state_nxt = pins.tms ? tap_update_dr : tap_pause_dr;
            tap_pause_dr:   state_nxt = pins.tms ? tap_exit2_dr : tap_pause_dr;
            tap_exit2_dr:   state_nxt = pins.tms ? tap_update_dr : tap_shift_dr;
            tap_update_dr:  state_nxt = pins.tms ? tap_select_dr : tap_idle;
            tap_select_ir:  state_nxt = pins.tms ? tap_reset : tap_capture_ir;
            tap_capture_ir: state_nxt = pins.tms ? tap_exit1_ir : tap_shift_ir;
            tap_shift_ir:   state_nxt = pins.tms ? tap_exit1_ir : tap_shift_ir;
            tap_exit1_ir:   state_nxt = pins.tms ? tap_update_ir : tap_pause_ir;
            tap_pause_ir:   state_nxt = pins.tms ? tap_exit2_ir : tap_pause_ir;
            tap_exit2_ir:   state_nxt = pins.tms ? tap_update_ir : tap_shift_ir;
            default:        state_nxt = pins.tms ? tap_select_dr : tap_idle;
        endcase
    end

    always_ff @(posedge pins.tck or posedge tap_rst)
    begin
        if (tap_rst)
        begin
            state <= tap_reset;
            ir <= `JTAG_INST_IDCODE;
        end
        else
        begin
            state <= state_nxt;
            // Test-Logic-Reset always falls back to IDCODE
            if (state == tap_reset)
                ir <= `JTAG_INST_IDCODE;
            else if (state == tap_update_ir)
                ir <= ir_sh;
        end
    end

    always_ff @(posedge pins.tck or posedge reset)
    begin
        if (reset)
            scratch <= '0;
        else if (state == tap_update_dr && ir == `JTAG_INST_SCRATCH)
            scratch <= dr_sh;
    end

    // Data enters at the top of the selected register and BYPASS is one bit long
    always_ff @(posedge pins.tck)
    begin
        case (state)
            tap_capture_ir: ir_sh <= `JTAG_IR_CAPTURE;
            tap_shift_ir:   ir_sh <= {pins.tdi, ir_sh[IRW - 1:1]};
            tap_capture_dr:
                if (ir == `JTAG_INST_IDCODE)
                    dr_sh <= dr_word_t'(`JTAG_IDCODE);
                else if (ir == `JTAG_INST_SCRATCH)
                    dr_sh <= scratch;
                else
                    dr_sh <= '0;
            tap_shift_dr:
                if (ir == `JTAG_INST_IDCODE)
                    dr_sh <= dr_word_t'({pins.tdi, dr_sh[31:1]});
                else if (ir == `JTAG_INST_SCRATCH)
                    dr_sh <= {pins.tdi, dr_sh[$bits(dr_word_t) - 1:1]};
                else
                    dr_sh <= dr_word_t'(pins.tdi);
            default: ;
        endcase
    end

    always_ff @(negedge pins.tck or posedge tap_rst)
    begin
        if (tap_rst)
            pins.tdo <= 1'b0;
        else if (state == tap_shift_ir)
            pins.tdo <= ir_sh[0];
        else if (state == tap_shift_dr)
            pins.tdo <= dr_sh[0];
    end

endmodule

`default_nettype wire

/* design/jtag_scan_shifter.sv */
// Shifts LSB first; captures are cleared on start so zero lengths return zero
`default_nettype none

module jtag_scan_shifter
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 start,
    input  wire jtag_pkg::ir_len_t    ir_len,
    input  wire jtag_pkg::ir_word_t   ir_in,
    input  wire jtag_pkg::dr_len_t    dr_len,
    input  wire jtag_pkg::dr_word_t   dr_in,
    input  wire jtag_pkg::tap_state_t state,
    input  wire logic                 tck_rise,
    input  wire logic                 tck_fall,
    output logic                      tdi,
    input  wire logic                 tdo,
    output jtag_pkg::ir_word_t        ir_captured,
    output jtag_pkg::dr_word_t        dr_captured
);

    import jtag_pkg::*;

    ir_word_t ir_tx;
    dr_word_t dr_tx;

    // TDI moves with falling TCK so the target sees it settled on the rise
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            tdi <= 1'b0;
        else if (tck_fall)
        begin
            if (state == tap_shift_ir)
                tdi <= ir_tx[0];
            else if (state == tap_shift_dr)
                tdi <= dr_tx[0];
        end
    end

    // TDO enters at the top of the requested length and ends right-aligned
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            ir_tx <= ir_in;
            dr_tx <= dr_in;
            ir_captured <= '0;
            dr_captured <= '0;
        end
        else if (tck_rise && state == tap_shift_ir)
        begin
            ir_tx <= ir_tx >> 1;
            ir_captured <= (ir_captured >> 1) | (ir_word_t'(tdo) << (ir_len - 1'b1));
        end
        else if (tck_rise && state == tap_shift_dr)
        begin
            dr_tx <= dr_tx >> 1;
            dr_captured <= (dr_captured >> 1) | (dr_word_t'(tdo) << (dr_len - 1'b1));
        end
    end

endmodule

`default_nettype wire

/* design/jtag_tms_sequencer.sv */
// Fixed TAP walk with no pause states; lengths and scan_reset must hold until done
`default_nettype none

`include "jtag_config.svh"

module jtag_tms_sequencer
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              start,
    input  wire logic              scan_reset,
    input  wire jtag_pkg::ir_len_t ir_len,
    input  wire jtag_pkg::dr_len_t dr_len,
    jtag_pins_if.host              pins,
    output jtag_pkg::tap_state_t   state,
    output logic                   tck_rise,
    output logic                   tck_fall,
    output logic                   done
);

    import jtag_pkg::*;

    localparam int DIV = `JTAG_TCK_DIVISOR;

    logic [$clog2(DIV + 1) - 1:0] div_cnt;
    logic tick;
    tap_state_t planned;
    tap_state_t want;
    logic want_tms;
    logic busy;
    logic ir_done;
    logic walk_end;
    dr_len_t bit_cnt;

    assign tick = (div_cnt == DIV);
    assign tck_rise = tick && !pins.tck;
    assign tck_fall = tick && pins.tck;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            pins.tck <= 1'b0;
        end
        else if (tick)
        begin
            div_cnt <= '0;
            pins.tck <= ~pins.tck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // Next state the walk heads for from the mirrored TAP state
    always_comb
    begin
        want = state;
        case (state)
            tap_reset:      want = tap_idle;
            tap_idle:       want = busy ? tap_select_dr : tap_idle;
            tap_select_dr:
                want = (scan_reset || (ir_len != '0 && !ir_done)) ? tap_select_ir
                                                                   : tap_capture_dr;
            tap_select_ir:  want = scan_reset ? tap_reset : tap_capture_ir;
            tap_capture_ir: want = tap_shift_ir;
            tap_shift_ir:   want = (bit_cnt == 1) ? tap_exit1_ir : tap_shift_ir;
            tap_exit1_ir:   want = tap_update_ir;
            tap_update_ir:  want = (dr_len != '0) ? tap_select_dr : tap_idle;
            tap_capture_dr: want = tap_shift_dr;
            tap_shift_dr:   want = (bit_cnt == 1) ? tap_exit1_dr : tap_shift_dr;
            tap_exit1_dr:   want = tap_update_dr;
            default:        want = tap_idle;
        endcase
    end

    // Each TAP state is entered with one TMS value only
    assign want_tms = want inside {tap_reset, tap_select_dr, tap_select_ir, tap_exit1_dr,
                                   tap_exit1_ir, tap_update_dr, tap_update_ir};

    // The walk ends on its return to Run-Test/Idle and the power-up exit from reset does not count
    assign walk_end = busy && planned == tap_idle && state != tap_idle
                      && (state != tap_reset || scan_reset);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pins.tms <= 1'b1;
            pins.trst_n <= 1'b0;
            planned <= tap_reset;
            state <= tap_reset;
            busy <= 1'b0;
            ir_done <= 1'b0;
            bit_cnt <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= tck_rise && walk_end;
            if (start)
            begin
                busy <= 1'b1;
                ir_done <= 1'b0;
            end
            if (tck_fall)
            begin
                pins.tms <= want_tms;
                pins.trst_n <= (want != tap_reset);
                planned <= want;
            end
            else if (tck_rise)
            begin
                state <= planned;
                if (walk_end)
                    busy <= 1'b0;
                if (state == tap_update_ir)
                    ir_done <= 1'b1;
                if (planned == tap_capture_ir)
                    bit_cnt <= dr_len_t'(ir_len);
                else if (planned == tap_capture_dr)
                    bit_cnt <= dr_len;
                else if (state == tap_shift_ir || state == tap_shift_dr)
                    bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/jtag_host_ctrl.sv */
// Request fields must stay stable from req until ack; both lengths zero requests a TAP reset
`default_nettype none

module jtag_host_ctrl
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               req,
    output logic                    ack,
    input  wire jtag_pkg::ir_len_t  ir_len,
    input  wire jtag_pkg::ir_word_t ir_in,
    input  wire jtag_pkg::dr_len_t  dr_len,
    input  wire jtag_pkg::dr_word_t dr_in,
    output logic                    start,
    output logic                    scan_reset,
    output jtag_pkg::ir_len_t       scan_ir_len,
    output jtag_pkg::ir_word_t      scan_ir,
    output jtag_pkg::dr_len_t       scan_dr_len,
    output jtag_pkg::dr_word_t      scan_dr,
    input  wire logic               done,
    input  wire jtag_pkg::ir_word_t ir_captured,
    input  wire jtag_pkg::dr_word_t dr_captured,
    output jtag_pkg::ir_word_t      ir_out,
    output jtag_pkg::dr_word_t      dr_out
);

    typedef enum logic [1:0] {ctrl_idle, ctrl_busy, ctrl_respond} ctrl_state_t;

    ctrl_state_t ctrl_state;

    // An empty request walks the TAP through Test-Logic-Reset
    assign scan_reset = (scan_ir_len == '0) && (scan_dr_len == '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ctrl_state <= ctrl_idle;
            start <= 1'b0;
            ack <= 1'b0;
            scan_ir_len <= '0;
            scan_dr_len <= '0;
        end
        else
        begin
            start <= 1'b0;
            case (ctrl_state)
                ctrl_idle:
                    if (req)
                    begin
                        start <= 1'b1;
                        scan_ir_len <= ir_len;
                        scan_dr_len <= dr_len;
                        ctrl_state <= ctrl_busy;
                    end
                ctrl_busy:
                    if (done)
                    begin
                        ack <= 1'b1;
                        ctrl_state <= ctrl_respond;
                    end
                default:
                    // Hold the response until the requester lets go
                    if (!req)
                    begin
                        ack <= 1'b0;
                        ctrl_state <= ctrl_idle;
                    end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl_state == ctrl_idle && req)
        begin
            scan_ir <= ir_in;
            scan_dr <= dr_in;
        end
        if (ctrl_state == ctrl_busy && done)
        begin
            ir_out <= ir_captured;
            dr_out <= dr_captured;
        end
    end

endmodule

`default_nettype wire

/* design/jtag_pins_if.sv */
// The five JTAG pins; no boundary scan and TCK always comes from the host
`default_nettype none

interface jtag_pins_if;

    logic tck;
    logic tms;
    logic tdi;
    logic tdo;
    logic trst_n;

    // Host drives the clock, mode, data in and test reset
    modport host (output tck, output tms, output tdi, output trst_n, input tdo);

    // Target only drives data out
    modport target (input tck, input tms, input tdi, input trst_n, output tdo);

endinterface

`default_nettype wire

/* design/jtag_pkg.sv */
// Shared scan types; the length types must hold the maximum lengths inclusive
`default_nettype none

`include "jtag_config.svh"

package jtag_pkg;

    typedef logic [$clog2(`JTAG_MAX_IR_LEN + 1) - 1:0] ir_len_t;
    typedef logic [$clog2(`JTAG_MAX_DR_LEN + 1) - 1:0] dr_len_t;
    typedef logic [`JTAG_MAX_IR_LEN - 1:0] ir_word_t;
    typedef logic [`JTAG_MAX_DR_LEN - 1:0] dr_word_t;

    // Standard TAP controller states shared by the host mirror and the target
    typedef enum logic [3:0] {
        tap_reset, tap_idle,
        tap_select_dr, tap_capture_dr, tap_shift_dr, tap_exit1_dr,
        tap_pause_dr, tap_exit2_dr, tap_update_dr,
        tap_select_ir, tap_capture_ir, tap_shift_ir, tap_exit1_ir,
        tap_pause_ir, tap_exit2_ir, tap_update_ir
    } tap_state_t;

endpackage

`default_nettype wire

/* include/jtag_config.svh */
// Scan limits and target constants; the TCK divisor must be at least 1 and the IR width 4
`ifndef JTAG_CONFIG_SVH
`define JTAG_CONFIG_SVH

// A TCK half period lasts this many plus one clk cycles
`define JTAG_TCK_DIVISOR 3

`define JTAG_MAX_IR_LEN 32
`define JTAG_MAX_DR_LEN 64

// Target TAP instruction register
`define JTAG_TAP_IR_WIDTH 4
`define JTAG_IR_CAPTURE 4'b0101
`define JTAG_IDCODE 32'h4a7d_01c3
`define JTAG_INST_IDCODE 4'h1
`define JTAG_INST_SCRATCH 4'h2

`endif
